// File: flist.f
+incdir+hdl
hdl/aesPkg.sv
hdl/sboxGf.sv
hdl/keyExpand.sv
hdl/roundCipher.sv
hdl/aesCore.sv
hdl/aesRegs.sv
hdl/aesTop.sv
test/aesMonitor.sv
test/aes_checker.sv
test/aesTb.sv

// File: Bender.yml
package:
  name: aes_wb

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/aesPkg.sv
      - hdl/sboxGf.sv
      - hdl/keyExpand.sv
      - hdl/roundCipher.sv
      - hdl/aesCore.sv
      - hdl/aesRegs.sv
      - hdl/aesTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/aesMonitor.sv
      - test/aes_checker.sv
      - test/aesTb.sv

// File: test/aes_vectors.txt
# dir (0 encrypt, 1 decrypt), key, input block, expected output block
# all values hex, word 0 of each block is the most significant
0 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
0 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
0 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
0 2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
0 2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
0 2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
0 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
1 000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
1 2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a
1 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e 00000000000000000000000000000000

// File: test/aesTb.sv
// AES engine testbench
`default_nettype none
`include "aes_config.svh"

module aesClock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

endmodule

module aesTb
  import aesPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    AdrW      = `AES_ADDR_W;
  localparam int    CtrlAdr   = `AES_REG_CTRL;
  localparam int    StatusAdr = `AES_REG_STATUS;
  localparam int    KeyAdr    = `AES_REG_KEY0;
  localparam int    DinAdr    = `AES_REG_DIN0;
  localparam int    DoutAdr   = `AES_REG_DOUT0;
  localparam int    DriveDly  = 10;
  localparam int    AckWait   = 8;
  localparam int    MaxPolls  = 60;
  localparam string VecFile   = "test/aes_vectors.txt";

  logic            clk;
  logic            rstN;
  logic            wbCyc;
  logic            wbStb;
  logic            wbWe;
  logic [AdrW-1:0] wbAdr;
  logic [31:0]     wbDatW;
  logic [31:0]     wbDatR;
  logic            wbAck;
  // expectation handed to the monitor with each read
  logic            checkEn;
  logic [31:0]     expData;
  int              monErrors;
  int              driverErrors;
  int              limitCycles = 0;

  aesDirT       vecDir [$];
  logic [127:0] vecKey [$];
  logic [127:0] vecIn [$];
  logic [127:0] vecExp [$];

  aesClock aesClock_inst (
    .clk (clk)
  );

  aesTop aesTop_inst (
    .clk    (clk),
    .rstN   (rstN),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck)
  );

  aesMonitor aesMonitor_inst (
    .clk        (clk),
    .rstN       (rstN),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbWe       (wbWe),
    .wbAdr      (wbAdr),
    .wbDatR     (wbDatR),
    .wbAck      (wbAck),
    .checkEn    (checkEn),
    .expData    (expData),
    .errorCount (monErrors)
  );

  // skips comment and blank lines
  task automatic loadVectors(output logic ok);
    int           fd;
    string        line;
    logic [3:0]   d;
    logic [127:0] k;
    logic [127:0] i;
    logic [127:0] e;
    fd = $fopen(VecFile, "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#"
            && $sscanf(line, "%h %h %h %h", d, k, i, e) == 4) begin
          vecDir.push_back(aesDirT'(d[0]));
          vecKey.push_back(k);
          vecIn.push_back(i);
          vecExp.push_back(e);
        end
      end
      $fclose(fd);
      ok = (vecKey.size() > 0);
    end
  endtask

  // one classic cycle after a random idle gap
  task automatic busCycle(input logic we, input int adr, input logic [31:0] wdata,
                          input logic chk, input logic [31:0] exp,
                          output logic [31:0] rdata);
    int waited;
    repeat ($urandom % 4) @(posedge clk);
    @(posedge clk);
    #DriveDly;
    wbCyc   = 1'b1;
    wbStb   = 1'b1;
    wbWe    = we;
    wbAdr   = AdrW'(adr);
    wbDatW  = wdata;
    checkEn = chk;
    expData = exp;
    waited  = 0;
    do begin
      @(posedge clk);
      #DriveDly;
      waited++;
    end while (!wbAck && waited < AckWait);
    if (!wbAck) begin
      driverErrors++;
      $display("No ack for the bus %s at word %0d", we ? "write" : "read", adr);
    end
    rdata = wbDatR;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic busWrite(input int adr, input logic [31:0] data);
    logic [31:0] unused;
    busCycle(1'b1, adr, data, 1'b0, 32'h0, unused);
  endtask

  task automatic busRead(input int adr, output logic [31:0] data);
    busCycle(1'b0, adr, 32'h0, 1'b0, 32'h0, data);
  endtask

  task automatic checkRead(input int adr, input logic [31:0] exp);
    logic [31:0] unused;
    busCycle(1'b0, adr, 32'h0, 1'b1, exp, unused);
  endtask

  task automatic loadOperands(input logic [127:0] k, input logic [127:0] din);
    for (int w = 0; w < 4; w++) begin
      busWrite(KeyAdr + w, k[127-32*w -: 32]);
      busWrite(DinAdr + w, din[127-32*w -: 32]);
    end
  endtask

  task automatic checkResult(input logic [127:0] exp);
    for (int w = 0; w < 4; w++) begin
      checkRead(DoutAdr + w, exp[127-32*w -: 32]);
    end
  endtask

  // doneFlag counts only once the request was seen busy
  task automatic waitDone(input logic busySeen);
    logic [31:0] st;
    int          polls;
    st    = 32'h0;
    polls = 0;
    while (!(busySeen && st[1]) && polls < MaxPolls) begin
      busRead(StatusAdr, st);
      busySeen = busySeen | st[0];
      polls++;
    end
    if (!(busySeen && st[1])) begin
      driverErrors++;
      $display("Request did not complete after %0d status reads", polls);
    end
  endtask

  task automatic runBlock(input aesDirT dir, input logic [127:0] k,
                          input logic [127:0] din, input logic [127:0] exp);
    loadOperands(k, din);
    busWrite(CtrlAdr, {30'h0, dir == dirDec, 1'b1});
    waitDone(1'b0);
    checkResult(exp);
  endtask

  task automatic checkResetValues();
    checkRead(StatusAdr, 32'h0);
    checkResult(128'h0);
  endtask

  task automatic checkRegisterAccess();
    logic [31:0] pat [8];
    for (int w = 0; w < 8; w++) begin
      pat[w] = $urandom;
    end
    loadOperands({pat[0], pat[1], pat[2], pat[3]}, {pat[4], pat[5], pat[6], pat[7]});
    for (int w = 0; w < 4; w++) begin
      checkRead(KeyAdr + w, pat[w]);
      checkRead(DinAdr + w, pat[w+4]);
    end
    // holes in the map
    checkRead(2, 32'h0);
    checkRead(3, 32'h0);
    checkRead(16, 32'h0);
    checkRead((1 << AdrW) - 1, 32'h0);
  endtask

  // a decrypt go written during an encrypt run must be dropped
  task automatic checkBusyGo(input logic [127:0] k, input logic [127:0] pt,
                             input logic [127:0] ct);
    logic [31:0] st;
    int          polls;
    loadOperands(k, pt);
    busWrite(CtrlAdr, 32'h1);
    st    = 32'h0;
    polls = 0;
    while (!st[0] && polls < MaxPolls) begin
      busRead(StatusAdr, st);
      polls++;
    end
    if (!st[0]) begin
      driverErrors++;
      $display("Status never showed busy after go");
    end
    busWrite(CtrlAdr, 32'h3);
    waitDone(1'b1);
    checkResult(ct);
    repeat (30) @(posedge clk);
    // core back to idle after a single completion
    checkRead(StatusAdr, 32'h2);
    checkResult(ct);
    // the dropped write leaves the encrypt direction in place
    checkRead(CtrlAdr, 32'h0);
  endtask

  initial begin
    logic ok;
    int   pick;
    void'($urandom(32'ha5ada8b2));
    rstN         = 1'b0;
    wbCyc        = 1'b0;
    wbStb        = 1'b0;
    wbWe         = 1'b0;
    wbAdr        = '0;
    wbDatW       = 32'h0;
    checkEn      = 1'b0;
    expData      = 32'h0;
    driverErrors = 0;
    pick         = -1;
    loadVectors(ok);
    limitCycles = vecKey.size() * 400 + 1000;
    repeat (5) @(posedge clk);
    #DriveDly rstN = 1'b1;
    if (!ok) begin
      driverErrors++;
      $display("No vectors could be read from %s", VecFile);
    end else begin
      checkResetValues();
      checkRegisterAccess();
      foreach (vecKey[n]) begin
        runBlock(vecDir[n], vecKey[n], vecIn[n], vecExp[n]);
        // round trip back to the plaintext
        if (vecDir[n] == dirEnc) begin
          runBlock(dirDec, vecKey[n], vecExp[n], vecIn[n]);
          if (pick < 0) begin
            pick = n;
          end
        end
      end
      if (pick >= 0) begin
        checkBusyGo(vecKey[pick], vecIn[pick], vecExp[pick]);
      end
    end
    repeat (2) @(posedge clk);
    $display("Error counts: monitor %0d, bus driver %0d, assertions %0d", monErrors,
             driverErrors, aesTop_inst.aesRegs_inst.aesChecker_inst.assertFails);
    if (monErrors + driverErrors + aesTop_inst.aesRegs_inst.aesChecker_inst.assertFails
        == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog limit scales with the number of vectors
  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limitCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/aes_checker.sv
// Bus and handshake assertions
`default_nettype none

module aesChecker (
  input logic clk,
  input logic rstN,
  input logic wbCyc,
  input logic wbStb,
  input logic wbAck,
  input logic start,
  input logic busy,
  input logic done
);
  timeunit 1ns;
  timeprecision 100ps;

  // failed assertions, read by the testbench top
  int assertFails = 0;

  ackSingle: assert property (@(posedge clk) disable iff (!rstN) wbAck |=> !wbAck)
    else begin
      assertFails++;
      $error("wbAck stayed high for two cycles");
    end

  // ack answers a strobe seen on the previous edge
  ackOnStrobe: assert property (@(posedge clk) disable iff (!rstN)
    $rose(wbAck) |-> $past(wbCyc && wbStb))
    else begin
      assertFails++;
      $error("wbAck rose without an active strobe");
    end

  donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
    else begin
      assertFails++;
      $error("done lasted longer than one cycle");
    end

  startIdle: assert property (@(posedge clk) disable iff (!rstN) start |-> !busy)
    else begin
      assertFails++;
      $error("start was raised while the core was busy");
    end

endmodule

// register block sees both the bus and the core handshake
bind aesRegs aesChecker aesChecker_inst (
  .clk   (clk),
  .rstN  (rstN),
  .wbCyc (wbCyc),
  .wbStb (wbStb),
  .wbAck (wbAck),
  .start (start),
  .busy  (busy),
  .done  (done)
);

`default_nettype wire

// File: test/aesMonitor.sv
// Bus read data checker
`default_nettype none
`include "aes_config.svh"

module aesMonitor (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   wbCyc,
  input  logic                   wbStb,
  input  logic                   wbWe,
  input  logic [`AES_ADDR_W-1:0] wbAdr,
  input  logic [31:0]            wbDatR,
  input  logic                   wbAck,
  input  logic                   checkEn,
  input  logic [31:0]            expData,
  output int                     errorCount
);
  timeunit 1ns;
  timeprecision 100ps;

  // request seen on the bus, waiting for its ack
  logic                   pendValid;
  logic                   pendWe;
  logic                   pendChk;
  logic [`AES_ADDR_W-1:0] pendAdr;
  logic [31:0]            pendExp;

  initial begin
    errorCount = 0;
    pendValid  = 1'b0;
  end

  // mid-cycle sampling, all bus signals are settled here
  always @(negedge clk) begin
    if (rstN && wbAck) begin
      if (!pendValid) begin
        errorCount++;
        $display("wbAck was seen with no bus request pending");
      end else if (!pendWe && pendChk && (wbDatR !== pendExp)) begin
        errorCount++;
        $display("Mismatch wbDatR word %0d: got 0x%08h expected 0x%08h",
                 pendAdr, wbDatR, pendExp);
      end
      pendValid = 1'b0;
    end
    // capture a new request, acked on the following edge
    if (rstN && wbCyc && wbStb && !wbAck) begin
      pendValid = 1'b1;
      pendWe    = wbWe;
      pendChk   = checkEn;
      pendAdr   = wbAdr;
      pendExp   = expData;
    end
  end

endmodule

`default_nettype wire

// File: hdl/aesTop.sv
// AES engine top level
`default_nettype none
`include "aes_config.svh"

module aesTop
  import aesPkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   wbCyc,
  input  logic                   wbStb,
  input  logic                   wbWe,
  input  logic [`AES_ADDR_W-1:0] wbAdr,
  input  logic [31:0]            wbDatW,
  output logic [31:0]            wbDatR,
  output logic                   wbAck
);

  logic         start;
  aesDirT       dir;
  logic [127:0] key;
  logic [127:0] dataIn;
  logic         busy;
  logic         done;
  logic [127:0] dataOut;

  // bus side: registers and the start handshake
  aesRegs aesRegs_inst (
    .clk     (clk),
    .rstN    (rstN),
    .wbCyc   (wbCyc),
    .wbStb   (wbStb),
    .wbWe    (wbWe),
    .wbAdr   (wbAdr),
    .wbDatW  (wbDatW),
    .wbDatR  (wbDatR),
    .wbAck   (wbAck),
    .busy    (busy),
    .done    (done),
    .dataOut (dataOut),
    .start   (start),
    .dir     (dir),
    .key     (key),
    .dataIn  (dataIn)
  );

  aesCore aesCore_inst (
    .clk     (clk),
    .rstN    (rstN),
    .start   (start),
    .dir     (dir),
    .key     (key),
    .dataIn  (dataIn),
    .busy    (busy),
    .done    (done),
    .dataOut (dataOut)
  );

endmodule

`default_nettype wire

// File: hdl/aesRegs.sv
// Wishbone register block
`default_nettype none
`include "aes_config.svh"

module aesRegs
  import aesPkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   wbCyc,
  input  logic                   wbStb,
  input  logic                   wbWe,
  input  logic [`AES_ADDR_W-1:0] wbAdr,
  input  logic [31:0]            wbDatW,
  output logic [31:0]            wbDatR,
  output logic                   wbAck,
  input  logic                   busy,
  input  logic                   done,
  input  logic [127:0]           dataOut,
  output logic                   start,
  output aesDirT                 dir,
  output logic [127:0]           key,
  output logic [127:0]           dataIn
);

  localparam logic [`AES_ADDR_W-1:0] CtrlAdr   = (`AES_ADDR_W)'(`AES_REG_CTRL);
  localparam logic [`AES_ADDR_W-1:0] StatusAdr = (`AES_ADDR_W)'(`AES_REG_STATUS);
  localparam logic [`AES_ADDR_W-1:0] KeyBase   = (`AES_ADDR_W)'(`AES_REG_KEY0);
  localparam logic [`AES_ADDR_W-1:0] DinBase   = (`AES_ADDR_W)'(`AES_REG_DIN0);
  localparam logic [`AES_ADDR_W-1:0] DoutBase  = (`AES_ADDR_W)'(`AES_REG_DOUT0);

  logic [31:0]            keyW [4];
  logic [31:0]            dinW [4];
  logic [127:0]           result;
  logic                   doneFlag;
  logic                   access;
  logic                   wrEn;
  logic                   ctrlWr;
  logic [1:0]             wordIdx;
  logic [`AES_ADDR_W-1:0] groupBase;
  logic [31:0]            readVal;

  // new bus cycle, acked on the next edge
  assign access    = wbCyc & wbStb & ~wbAck;
  assign wrEn      = access & wbWe;
  assign wordIdx   = wbAdr[1:0];
  assign groupBase = {wbAdr[`AES_ADDR_W-1:2], 2'b00};
  // control word takes effect only while the core is free
  assign ctrlWr    = wrEn && (wbAdr == CtrlAdr) && !busy && !start;

  // control word: bit 0 go, bit 1 direction (1 decrypts)
  // status word: bit 0 busy, bit 1 doneFlag
  always_comb begin
    readVal = 32'h0;
    if (wbAdr == CtrlAdr) begin
      readVal = {30'h0, dir, 1'b0};
    end else if (wbAdr == StatusAdr) begin
      readVal = {30'h0, doneFlag, busy};
    end else if (groupBase == KeyBase) begin
      readVal = keyW[wordIdx];
    end else if (groupBase == DinBase) begin
      readVal = dinW[wordIdx];
    end else if (groupBase == DoutBase) begin
      readVal = result[127-32*wordIdx -: 32];
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbAck    <= 1'b0;
      wbDatR   <= 32'h0;
      start    <= 1'b0;
      dir      <= dirEnc;
      doneFlag <= 1'b0;
      result   <= '0;
    end else begin
      wbAck <= access;
      if (access) begin
        wbDatR <= readVal;
      end
      // one-cycle go pulse
      start <= ctrlWr && wbDatW[0];
      if (ctrlWr) begin
        dir <= aesDirT'(wbDatW[1]);
      end
      // doneFlag stays set until the next request starts
      if (done) begin
        result   <= dataOut;
        doneFlag <= 1'b1;
      end else if (start) begin
        doneFlag <= 1'b0;
      end
    end
  end

  // operands stay frozen while a block is in flight
  always_ff @(posedge clk) begin
    if (wrEn && !busy) begin
      if (groupBase == KeyBase) begin
        keyW[wordIdx] <= wbDatW;
      end
      if (groupBase == DinBase) begin
        dinW[wordIdx] <= wbDatW;
      end
    end
  end

  assign key    = {keyW[0], keyW[1], keyW[2], keyW[3]};
  assign dataIn = {dinW[0], dinW[1], dinW[2], dinW[3]};

endmodule

`default_nettype wire

// File: hdl/aesCore.sv
// AES-128 core sequencer
`default_nettype none
`include "aes_config.svh"

module aesCore
  import aesPkg::*;
(
  input  logic         clk,
  input  logic         rstN,
  input  logic         start,
  input  aesDirT       dir,
  input  logic [127:0] key,
  input  logic [127:0] dataIn,
  output logic         busy,
  output logic         done,
  output logic [127:0] dataOut
);

  localparam logic [4:0] LastStep = 5'(`AES_ROUNDS - 1);
  localparam logic [4:0] LoadStep = 5'(`AES_ROUNDS);

  aesStateT     seqState;
  aesStateT     seqNext;
  aesDirT       dirQ;
  logic [4:0]   cnt;
  logic         keyLoad;
  logic         keyStep;
  logic         keyBack;
  logic         cipherLoad;
  logic         cipherStep;
  logic         lastRound;
  logic [127:0] roundKey;
  logic [127:0] cipherState;

  always_comb begin
    seqNext    = seqState;
    keyLoad    = 1'b0;
    keyStep    = 1'b0;
    keyBack    = 1'b0;
    cipherLoad = 1'b0;
    cipherStep = 1'b0;
    lastRound  = 1'b0;
    case (seqState)
      stIdle: begin
        if (start) begin
          keyLoad = 1'b1;
          // encryption loads the state together with the key
          cipherLoad = (dir == dirEnc);
          seqNext    = (dir == dirEnc) ? stRounds : stKeyWalk;
        end
      end
      stKeyWalk: begin
        // ten forward steps to the last round key, then load the block
        if (cnt == LoadStep) begin
          cipherLoad = 1'b1;
          seqNext    = stRounds;
        end else begin
          keyStep = 1'b1;
        end
      end
      stRounds: begin
        cipherStep = 1'b1;
        keyStep    = (dirQ == dirEnc);
        keyBack    = (dirQ == dirDec);
        lastRound  = (cnt == LastStep);
        if (cnt == LastStep) begin
          seqNext = stFinish;
        end
      end
      stFinish: seqNext = stIdle;
      default:  seqNext = stIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      seqState <= stIdle;
      cnt      <= '0;
      dirQ     <= dirEnc;
    end else begin
      seqState <= seqNext;
      // count restarts at each phase change
      if (seqNext != seqState || seqState == stIdle) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 5'd1;
      end
      // direction held for the whole request
      if (seqState == stIdle && start) begin
        dirQ <= dir;
      end
    end
  end

  keyExpand keyExpand_inst (
    .clk      (clk),
    .rstN     (rstN),
    .keyLoad  (keyLoad),
    .keyStep  (keyStep),
    .keyBack  (keyBack),
    .key      (key),
    .roundKey (roundKey)
  );

  roundCipher roundCipher_inst (
    .clk        (clk),
    .rstN       (rstN),
    .cipherLoad (cipherLoad),
    .cipherStep (cipherStep),
    .lastRound  (lastRound),
    .dir        (dirQ),
    .roundKey   (roundKey),
    .dataIn     (dataIn),
    .state      (cipherState)
  );

  assign busy    = (seqState != stIdle);
  assign done    = (seqState == stFinish);
  assign dataOut = cipherState;

endmodule

`default_nettype wire

// File: hdl/roundCipher.sv
// AES round datapath
`default_nettype none

module roundCipher
  import aesPkg::*;
(
  input  logic         clk,
  input  logic         rstN,
  input  logic         cipherLoad,
  input  logic         cipherStep,
  input  logic         lastRound,
  input  aesDirT       dir,
  input  logic [127:0] roundKey,
  input  logic [127:0] dataIn,
  output logic [127:0] state
);

  // byte (r, c) of the state sits at bits 127-8*(r+4c) downward
  function automatic logic [127:0] rowShift(input logic [127:0] s, input logic inv);
    logic [127:0] o;
    int src;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        // row r rotates left by r, or right by r for the inverse
        src = inv ? ((c - r + 4) % 4) : ((c + r) % 4);
        o[127-8*(r+4*c) -: 8] = s[127-8*(r+4*src) -: 8];
      end
    end
    return o;
  endfunction

  function automatic logic [7:0] xt(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // multiply by a constant below 16, enough for both mixing matrices
  function automatic logic [7:0] mulSmall(input logic [7:0] a, input logic [3:0] k);
    logic [7:0] a2;
    logic [7:0] a4;
    logic [7:0] a8;
    a2 = xt(a);
    a4 = xt(a2);
    a8 = xt(a4);
    return (k[0] ? a : 8'h00) ^ (k[1] ? a2 : 8'h00) ^ (k[2] ? a4 : 8'h00)
           ^ (k[3] ? a8 : 8'h00);
  endfunction

  function automatic logic [31:0] mixCol(input logic [31:0] col, input logic inv);
    logic [7:0]  a [4];
    logic [3:0]  coef [4];
    logic [31:0] o;
    for (int r = 0; r < 4; r++) begin
      a[r] = col[31-8*r -: 8];
    end
    // first row of the circulant matrix, {02 03 01 01} or {0e 0b 0d 09}
    coef[0] = inv ? 4'he : 4'h2;
    coef[1] = inv ? 4'hb : 4'h3;
    coef[2] = inv ? 4'hd : 4'h1;
    coef[3] = inv ? 4'h9 : 4'h1;
    for (int r = 0; r < 4; r++) begin
      o[31-8*r -: 8] = 8'h00;
      for (int k = 0; k < 4; k++) begin
        o[31-8*r -: 8] = o[31-8*r -: 8] ^ mulSmall(a[(k+r)%4], coef[k]);
      end
    end
    return o;
  endfunction

  function automatic logic [127:0] mixAll(input logic [127:0] s, input logic inv);
    logic [127:0] o;
    for (int c = 0; c < 4; c++) begin
      o[127-32*c -: 32] = mixCol(s[127-32*c -: 32], inv);
    end
    return o;
  endfunction

  logic         decrypt;
  logic [127:0] sboxIn;
  logic [127:0] sboxOut;
  logic [127:0] encMid;
  logic [127:0] decMid;
  logic [127:0] nextState;

  assign decrypt = (dir == dirDec);

  // InvShiftRows goes before the S-boxes, ShiftRows after
  assign sboxIn = decrypt ? rowShift(state, 1'b1) : state;

  for (genvar i = 0; i < 16; i++) begin : gSub
    sboxGf sboxGf_inst (
      .inverse (decrypt),
      .inByte  (sboxIn[8*i +: 8]),
      .outByte (sboxOut[8*i +: 8])
    );
  end

  always_comb begin
    encMid = rowShift(sboxOut, 1'b0);
    // inverse round adds the key before InvMixColumns
    decMid = sboxOut ^ roundKey;
    if (decrypt) begin
      nextState = lastRound ? decMid : mixAll(decMid, 1'b1);
    end else begin
      nextState = (lastRound ? encMid : mixAll(encMid, 1'b0)) ^ roundKey;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= '0;
    end else if (cipherLoad) begin
      // initial AddRoundKey
      state <= dataIn ^ roundKey;
    end else if (cipherStep) begin
      state <= nextState;
    end
  end

endmodule

`default_nettype wire

// File: hdl/keyExpand.sv
// AES-128 round key schedule
`default_nettype none

module keyExpand (
  input  logic         clk,
  input  logic         rstN,
  input  logic         keyLoad,
  input  logic         keyStep,
  input  logic         keyBack,
  input  logic [127:0] key,
  output logic [127:0] roundKey
);

  logic [127:0] keyQ;
  logic [7:0]   rconQ;
  logic [7:0]   rconPrev;
  logic [31:0]  w0, w1, w2, w3;
  logic [31:0]  prev3;
  logic [31:0]  subIn;
  logic [31:0]  subOut;
  logic [127:0] fwdKey;
  logic [127:0] backKey;

  assign {w0, w1, w2, w3} = keyQ;

  // rcon divided by x, undoes the xtime of a forward step
  assign rconPrev = rconQ[0] ? (((rconQ ^ 8'h1b) >> 1) | 8'h80) : (rconQ >> 1);

  // backward step needs the earlier w3 before SubWord
  assign prev3 = w3 ^ w2;
  // RotWord sits ahead of the S-boxes
  assign subIn = keyBack ? {prev3[23:0], prev3[31:24]} : {w3[23:0], w3[31:24]};

  for (genvar i = 0; i < 4; i++) begin : gSub
    sboxGf sboxGf_inst (
      .inverse (1'b0),
      .inByte  (subIn[8*i +: 8]),
      .outByte (subOut[8*i +: 8])
    );
  end

  always_comb begin
    // forward XOR chain from w0 to w3
    fwdKey[127:96] = w0 ^ subOut ^ {rconQ, 24'h0};
    fwdKey[95:64]  = w1 ^ fwdKey[127:96];
    fwdKey[63:32]  = w2 ^ fwdKey[95:64];
    fwdKey[31:0]   = w3 ^ fwdKey[63:32];
    // undo the chain starting from the last word
    backKey[31:0]   = prev3;
    backKey[63:32]  = w2 ^ w1;
    backKey[95:64]  = w1 ^ w0;
    backKey[127:96] = w0 ^ subOut ^ {rconPrev, 24'h0};
  end

  // key in use this cycle: a step hands the cipher the key it is moving to
  always_comb begin
    if (keyLoad) begin
      roundKey = key;
    end else if (keyStep) begin
      roundKey = fwdKey;
    end else if (keyBack) begin
      roundKey = backKey;
    end else begin
      roundKey = keyQ;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      keyQ  <= '0;
      rconQ <= 8'h01;
    end else if (keyLoad) begin
      keyQ  <= key;
      rconQ <= 8'h01;
    end else if (keyStep) begin
      keyQ  <= fwdKey;
      rconQ <= {rconQ[6:0], 1'b0} ^ (rconQ[7] ? 8'h1b : 8'h00);
    end else if (keyBack) begin
      keyQ  <= backKey;
      rconQ <= rconPrev;
    end
  end

endmodule

`default_nettype wire

// File: hdl/sboxGf.sv
// GF(2^8) S-box
`default_nettype none

module sboxGf (
  input  logic       inverse,
  input  logic [7:0] inByte,
  output logic [7:0] outByte
);

  // product modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
    end
    return acc;
  endfunction

  function automatic logic [7:0] rotl(input logic [7:0] a, input int n);
    return (a << n) | (a >> (8 - n));
  endfunction

  logic [7:0] invIn;
  logic [7:0] pow [8];
  logic [7:0] invByte;

  always_comb begin
    // inverse box undoes the affine map before inverting
    invIn = inverse ? (rotl(inByte, 1) ^ rotl(inByte, 3) ^ rotl(inByte, 6) ^ 8'h05) : inByte;
    // pow[k] holds invIn raised to 2^k
    pow[0] = invIn;
    for (int k = 1; k < 8; k++) begin
      pow[k] = gfMul(pow[k-1], pow[k-1]);
    end
    // x^254 = x^-1, and zero maps to zero by itself
    invByte = pow[1];
    for (int k = 2; k < 8; k++) begin
      invByte = gfMul(invByte, pow[k]);
    end
    // forward box applies the affine map after inverting
    if (inverse) begin
      outByte = invByte;
    end else begin
      outByte = invByte ^ rotl(invByte, 1) ^ rotl(invByte, 2) ^ rotl(invByte, 3)
                ^ rotl(invByte, 4) ^ 8'h63;
    end
  end

endmodule

`default_nettype wire

// File: hdl/aesPkg.sv
// AES engine types
`default_nettype none

package aesPkg;

  // operation direction
  // same encoding as bit 1 of the control word
  typedef enum logic {
    dirEnc = 1'b0,
    dirDec = 1'b1
  } aesDirT;

  // sequencer state of the core
  // keyWalk only happens for decryption
  typedef enum logic [1:0] {
    stIdle    = 2'd0,
    stKeyWalk = 2'd1,
    stRounds  = 2'd2,
    stFinish  = 2'd3
  } aesStateT;

endpackage

`default_nettype wire

// File: hdl/aes_config.svh
// AES engine configuration
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// cipher rounds for a 128-bit key
`define AES_ROUNDS 10

// width of the bus word address
`define AES_ADDR_W 6

// register word addresses, word 0 of a group is the most significant word
`define AES_REG_CTRL   0
`define AES_REG_STATUS 1
`define AES_REG_KEY0   4
`define AES_REG_DIN0   8
`define AES_REG_DOUT0  12

`endif
